/* logic/dotPkg.sv */
// Shared definitions for the pixel overlay subsystem.
// Holds the raster size, the coordinate, edge and color widths,
// the register field codes and the scan state encoding.
// Other files reach these by scoped names such as dotPkg::colorT.

`default_nettype none

package dotPkg;

	// ------------------------------------------------------------------------
	// Raster geometry, kept small for simulation
	// ------------------------------------------------------------------------
	localparam int HActive   = 16;
	localparam int HTotal    = 20;
	localparam int VActive   = 12;
	localparam int VTotal    = 14;

	// Number of overlay rectangles
	localparam int RectCount = 7;

	// ------------------------------------------------------------------------
	// Widths with a meaning
	// ------------------------------------------------------------------------
	// Raster coordinates, counting blank positions too
	typedef logic [4:0] hPosT;
	typedef logic [3:0] vPosT;

	// Rectangle edges carry a sign bit so they can sit off screen
	typedef logic signed [5:0] hEdgeT;
	typedef logic signed [4:0] vEdgeT;

	// RGB565 pixel
	typedef logic [15:0] colorT;

	// Host write port
	typedef logic [5:0]  regAddrT;
	typedef logic [15:0] regDataT;

	// ------------------------------------------------------------------------
	// Register field codes, low 3 bits of the write address
	// ------------------------------------------------------------------------
	localparam logic [2:0] FieldColor = 3'd0;
	localparam logic [2:0] FieldLeft  = 3'd1;
	localparam logic [2:0] FieldRight = 3'd2;
	localparam logic [2:0] FieldTop   = 3'd3;
	localparam logic [2:0] FieldUnder = 3'd4;
	localparam logic [2:0] FieldHalf  = 3'd5;

	// Raster walk phases
	typedef enum logic [1:0]
	{
		sActive,
		sHBlank,
		sVBlank
	} scanStateT;

endpackage

`default_nettype wire

/* logic/pixelIf.sv */
// Pixel stream between overlay stages.
// Carries the pixel color with its valid level, its raster position
// and a one-cycle frame start flag that comes with pixel (0,0).
// The sender drives every signal; receivers only sample.

`timescale 1ns/1ps
`default_nettype none

interface pixelIf;

	dotPkg::colorT pd;
	logic          pv;
	dotPkg::hPosT  hpos;
	dotPkg::vPosT  vpos;
	logic          frameStart;

	modport sender
	(
		output pd, pv, hpos, vpos, frameStart
	);

	// Stages downstream of the source
	modport receiver
	(
		input pd, pv, hpos, vpos, frameStart
	);

endinterface

`default_nettype wire

/* logic/rectIf.sv */
// Active rectangle set as seen by the drawing stage.
// One entry per rectangle: color, signed edges and the half strength flag.
// The register bank owns the set; the hit test only reads it.

`timescale 1ns/1ps
`default_nettype none

interface rectIf;

	dotPkg::colorT color [dotPkg::RectCount];
	dotPkg::hEdgeT left  [dotPkg::RectCount];
	dotPkg::hEdgeT right [dotPkg::RectCount];
	dotPkg::vEdgeT top   [dotPkg::RectCount];
	dotPkg::vEdgeT under [dotPkg::RectCount];
	logic [dotPkg::RectCount-1:0] half;

	modport owner
	(
		output color, left, right, top, under, half
	);

	modport reader
	(
		input color, left, right, top, under, half
	);

endinterface

`default_nettype wire

/* logic/scanControl.sv */
// Raster scan source for the overlay pipeline.
// Walks visible pixels, horizontal blank and vertical blank, and emits
// registered coordinates with pv on visible pixels and frameStart on
// pixel (0,0). Counting begins in the first cycle after reset.

`timescale 1ns/1ps
`default_nettype none

module scanControl
(
	input  logic    iCLK,
	input  logic    iRST,
	pixelIf.sender  pix
);

	dotPkg::scanStateT state;
	dotPkg::scanStateT stateNext;
	dotPkg::hPosT      hCnt;
	dotPkg::hPosT      hNext;
	dotPkg::vPosT      vCnt;
	dotPkg::vPosT      vNext;
	logic              pvReg;
	logic              fsReg;
	logic              hLast;

	assign hLast = (hCnt == dotPkg::hPosT'(dotPkg::HTotal - 1));

	// ------------------------------------------------------------------------
	// Next position and phase
	// ------------------------------------------------------------------------
	always_comb
	begin
		stateNext = state;
		hNext     = hCnt + 1'b1;
		vNext     = vCnt;
		case (state)
			dotPkg::sActive:
			begin
				if (hCnt == dotPkg::hPosT'(dotPkg::HActive - 1))
					stateNext = dotPkg::sHBlank;
			end
			dotPkg::sHBlank:
			begin
				if (hLast)
				begin
					hNext = '0;
					vNext = vCnt + 1'b1;
					// Last visible line goes into vertical blank
					if (vCnt == dotPkg::vPosT'(dotPkg::VActive - 1))
						stateNext = dotPkg::sVBlank;
					else
						stateNext = dotPkg::sActive;
				end
			end
			dotPkg::sVBlank:
			begin
				if (hLast)
				begin
					hNext = '0;
					if (vCnt == dotPkg::vPosT'(dotPkg::VTotal - 1))
					begin
						vNext     = '0;
						stateNext = dotPkg::sActive;
					end
					else
						vNext = vCnt + 1'b1;
				end
			end
			default: stateNext = dotPkg::sVBlank;
		endcase
	end

	// Reset parks the walk on the last blank pixel, so (0,0) comes next
	always_ff @(posedge iCLK)
	begin
		if (iRST)
		begin
			state <= dotPkg::sVBlank;
			hCnt  <= dotPkg::hPosT'(dotPkg::HTotal - 1);
			vCnt  <= dotPkg::vPosT'(dotPkg::VTotal - 1);
			pvReg <= 1'b0;
			fsReg <= 1'b0;
		end
		else
		begin
			state <= stateNext;
			hCnt  <= hNext;
			vCnt  <= vNext;
			pvReg <= (stateNext == dotPkg::sActive);
			fsReg <= (stateNext == dotPkg::sActive) && (hNext == '0) && (vNext == '0);
		end
	end

	assign pix.pd         = '0;
	assign pix.pv         = pvReg;
	assign pix.hpos       = hCnt;
	assign pix.vpos       = vCnt;
	assign pix.frameStart = fsReg;

	pvInsideLine: assert property (@(posedge iCLK) disable iff (iRST)
		pix.pv |-> (pix.hpos < dotPkg::hPosT'(dotPkg::HActive)))
		else $error("scanControl: pv high at hpos %0d", pix.hpos);

endmodule

`default_nettype wire

/* logic/squareRegs.sv */
// Rectangle register bank with host writes.
// Writes land in a pending bank; the whole pending bank is copied to
// the active bank at the frame start. During that frame start cycle
// the pending values are shown, so the new set covers pixel (0,0).
// Address: upper 3 bits pick the rectangle, lower 3 bits the field.

`timescale 1ns/1ps
`default_nettype none

module squareRegs
(
	input  logic            iCLK,
	input  logic            iRST,
	input  logic            iWrEn,
	input  dotPkg::regAddrT iWrAddr,
	input  dotPkg::regDataT iWrData,
	pixelIf.receiver        pix,
	rectIf.owner            rect
);

	logic [2:0] wrIdx;
	logic [2:0] wrField;

	// Pending bank written by the host
	dotPkg::colorT penColor [dotPkg::RectCount];
	dotPkg::hEdgeT penLeft  [dotPkg::RectCount];
	dotPkg::hEdgeT penRight [dotPkg::RectCount];
	dotPkg::vEdgeT penTop   [dotPkg::RectCount];
	dotPkg::vEdgeT penUnder [dotPkg::RectCount];
	logic [dotPkg::RectCount-1:0] penHalf;

	// Active bank used for drawing
	dotPkg::colorT actColor [dotPkg::RectCount];
	dotPkg::hEdgeT actLeft  [dotPkg::RectCount];
	dotPkg::hEdgeT actRight [dotPkg::RectCount];
	dotPkg::vEdgeT actTop   [dotPkg::RectCount];
	dotPkg::vEdgeT actUnder [dotPkg::RectCount];
	logic [dotPkg::RectCount-1:0] actHalf;

	assign wrIdx   = iWrAddr[5:3];
	assign wrField = iWrAddr[2:0];

	always_ff @(posedge iCLK)
	begin
		if (iRST)
		begin
			for (int i = 0; i < dotPkg::RectCount; i++)
			begin
				penColor[i] <= '0;
				penLeft[i]  <= '0;
				penRight[i] <= '0;
				penTop[i]   <= '0;
				penUnder[i] <= '0;
				actColor[i] <= '0;
				actLeft[i]  <= '0;
				actRight[i] <= '0;
				actTop[i]   <= '0;
				actUnder[i] <= '0;
			end
			penHalf <= '0;
			actHalf <= '0;
		end
		else
		begin
			if (iWrEn)
			begin
				case (wrField)
					dotPkg::FieldColor: penColor[wrIdx] <= iWrData;
					dotPkg::FieldLeft:  penLeft[wrIdx]  <= iWrData[$bits(dotPkg::hEdgeT)-1:0];
					dotPkg::FieldRight: penRight[wrIdx] <= iWrData[$bits(dotPkg::hEdgeT)-1:0];
					dotPkg::FieldTop:   penTop[wrIdx]   <= iWrData[$bits(dotPkg::vEdgeT)-1:0];
					dotPkg::FieldUnder: penUnder[wrIdx] <= iWrData[$bits(dotPkg::vEdgeT)-1:0];
					dotPkg::FieldHalf:  penHalf[wrIdx]  <= iWrData[0];
					default: ;
				endcase
			end
			// Commit takes the pending values from before this edge
			if (pix.frameStart)
			begin
				actColor <= penColor;
				actLeft  <= penLeft;
				actRight <= penRight;
				actTop   <= penTop;
				actUnder <= penUnder;
				actHalf  <= penHalf;
			end
		end
	end

	always_comb
	begin
		for (int i = 0; i < dotPkg::RectCount; i++)
		begin
			rect.color[i] = pix.frameStart ? penColor[i] : actColor[i];
			rect.left[i]  = pix.frameStart ? penLeft[i]  : actLeft[i];
			rect.right[i] = pix.frameStart ? penRight[i] : actRight[i];
			rect.top[i]   = pix.frameStart ? penTop[i]   : actTop[i];
			rect.under[i] = pix.frameStart ? penUnder[i] : actUnder[i];
		end
		rect.half = pix.frameStart ? penHalf : actHalf;
	end

	wrIdxInRange: assert property (@(posedge iCLK) disable iff (iRST)
		iWrEn |-> (wrIdx < 3'(dotPkg::RectCount)))
		else $error("squareRegs: write to rectangle %0d", wrIdx);

endmodule

`default_nettype wire

/* logic/dotSquareGen.sv */
// Rectangle hit test for the overlay.
// Each visible pixel is tested against all rectangles of the active set;
// the highest matching index picks the color and the half flag.
// Output is one cycle behind the input, with oHit and oHalf alongside.
// Edges are signed, so rectangles partly off screen still draw.

`timescale 1ns/1ps
`default_nettype none

module dotSquareGen
(
	input  logic     iCLK,
	input  logic     iRST,
	pixelIf.receiver pixIn,
	pixelIf.sender   pixOut,
	rectIf.reader    rect,
	output logic     oHit,
	output logic     oHalf
);

	dotPkg::hEdgeT hExt;
	dotPkg::vEdgeT vExt;
	logic [dotPkg::RectCount-1:0] match;
	dotPkg::colorT selColor;
	logic          selHalf;

	// Coordinates are never negative; a zero sign bit makes the compare signed
	assign hExt = dotPkg::hEdgeT'({1'b0, pixIn.hpos});
	assign vExt = dotPkg::vEdgeT'({1'b0, pixIn.vpos});

	always_comb
	begin
		for (int i = 0; i < dotPkg::RectCount; i++)
		begin
			match[i] = pixIn.pv
				&& (rect.left[i] <= hExt) && (hExt < rect.right[i])
				&& (rect.top[i] <= vExt) && (vExt < rect.under[i]);
		end
	end

	// Later indices overwrite earlier ones, highest index wins
	always_comb
	begin
		selColor = '0;
		selHalf  = 1'b0;
		for (int i = 0; i < dotPkg::RectCount; i++)
		begin
			if (match[i])
			begin
				selColor = rect.color[i];
				selHalf  = rect.half[i];
			end
		end
	end

	always_ff @(posedge iCLK)
	begin
		pixOut.pd   <= selColor;
		pixOut.hpos <= pixIn.hpos;
		pixOut.vpos <= pixIn.vpos;
		if (iRST)
		begin
			pixOut.pv         <= 1'b0;
			pixOut.frameStart <= 1'b0;
			oHit              <= 1'b0;
			oHalf             <= 1'b0;
		end
		else
		begin
			pixOut.pv         <= pixIn.pv;
			pixOut.frameStart <= pixIn.frameStart;
			oHit              <= |match;
			oHalf             <= selHalf;
		end
	end

	hitOnlyWhenValid: assert property (@(posedge iCLK) disable iff (iRST)
		oHit |-> pixOut.pv)
		else $error("dotSquareGen: hit on a blank pixel");

endmodule

`default_nettype wire

/* logic/dotBlend.sv */
// Final blend stage of the overlay.
// Without a hit the background color passes; an opaque hit shows the
// rectangle color; a half hit averages rectangle and background per
// RGB565 channel, rounding down. Registered one cycle.

`timescale 1ns/1ps
`default_nettype none

module dotBlend
(
	input  logic          iCLK,
	input  logic          iRST,
	input  dotPkg::colorT iBgColor,
	pixelIf.receiver      pixIn,
	input  logic          iHit,
	input  logic          iHalf,
	output dotPkg::colorT oPd,
	output logic          oPv,
	output dotPkg::hPosT  oHpos,
	output dotPkg::vPosT  oVpos,
	output logic          oFrameStart
);

	dotPkg::colorT mixColor;

	// Per channel (a + b) / 2, carry kept in the extra bit
	function automatic dotPkg::colorT halfMix(input dotPkg::colorT a, input dotPkg::colorT b);
		logic [5:0] r;
		logic [6:0] g;
		logic [5:0] bl;
		r  = {1'b0, a[15:11]} + {1'b0, b[15:11]};
		g  = {1'b0, a[10:5]}  + {1'b0, b[10:5]};
		bl = {1'b0, a[4:0]}   + {1'b0, b[4:0]};
		return {r[5:1], g[6:1], bl[5:1]};
	endfunction

	always_comb
	begin
		if (!iHit)
			mixColor = iBgColor;
		else if (iHalf)
			mixColor = halfMix(pixIn.pd, iBgColor);
		else
			mixColor = pixIn.pd;
	end

	always_ff @(posedge iCLK)
	begin
		oPd   <= mixColor;
		oHpos <= pixIn.hpos;
		oVpos <= pixIn.vpos;
		if (iRST)
		begin
			oPv         <= 1'b0;
			oFrameStart <= 1'b0;
		end
		else
		begin
			oPv         <= pixIn.pv;
			oFrameStart <= pixIn.frameStart;
		end
	end

	pvOneCycle: assert property (@(posedge iCLK) disable iff (iRST)
		oPv == $past(pixIn.pv))
		else $error("dotBlend: oPv out of step with input");

endmodule

`default_nettype wire

/* logic/dotOverlayTop.sv */
// Top level of the rectangle overlay subsystem.
// A host loads rectangles through iWrEn/iWrAddr/iWrData; they take effect
// at the next frame start. Pixels leave on oPd/oPv two cycles after the
// scan issues them, with position and frame start kept in step.

`timescale 1ns/1ps
`default_nettype none

module dotOverlayTop
(
	input  logic            iCLK,
	input  logic            iRST,
	input  logic            iWrEn,
	input  dotPkg::regAddrT iWrAddr,
	input  dotPkg::regDataT iWrData,
	input  dotPkg::colorT   iBgColor,
	output dotPkg::colorT   oPd,
	output logic            oPv,
	output dotPkg::hPosT    oHpos,
	output dotPkg::vPosT    oVpos,
	output logic            oFrameStart
);

	// Scan output and hit test output
	pixelIf scanPix ();
	pixelIf genPix ();
	rectIf  rectBus ();

	logic hit;
	logic half;

	scanControl uScan
	(
		.iCLK (iCLK),
		.iRST (iRST),
		.pix  (scanPix.sender)
	);

	squareRegs uRegs
	(
		.iCLK    (iCLK),
		.iRST    (iRST),
		.iWrEn   (iWrEn),
		.iWrAddr (iWrAddr),
		.iWrData (iWrData),
		.pix     (scanPix.receiver),
		.rect    (rectBus.owner)
	);

	dotSquareGen uGen
	(
		.iCLK   (iCLK),
		.iRST   (iRST),
		.pixIn  (scanPix.receiver),
		.pixOut (genPix.sender),
		.rect   (rectBus.reader),
		.oHit   (hit),
		.oHalf  (half)
	);

	dotBlend uBlend
	(
		.iCLK        (iCLK),
		.iRST        (iRST),
		.iBgColor    (iBgColor),
		.pixIn       (genPix.receiver),
		.iHit        (hit),
		.iHalf       (half),
		.oPd         (oPd),
		.oPv         (oPv),
		.oHpos       (oHpos),
		.oVpos       (oVpos),
		.oFrameStart (oFrameStart)
	);

endmodule

`default_nettype wire

/* dv/dotOverlayTb.sv */
// Testbench for the rectangle overlay top level.
// Loads rectangles over the host write port, keeps its own pending and
// active banks, and predicts every output pixel from the overlay rules.
// Concurrent assertions compare color, valid level, position and frame
// timing; the run ends with one line of error counts and a verdict.

`timescale 1ns/1ps
`default_nettype none

module dotOverlayTb;

	localparam int FrameLen  = dotPkg::HTotal * dotPkg::VTotal;
	localparam int PixPerFrm = dotPkg::HActive * dotPkg::VActive;
	localparam int WaitLimit = 2 * FrameLen;
	// Negedges from reset release to the first output frame start
	// One scan edge plus two pipeline stages
	localparam int FirstFs   = 4;

	logic            iCLK;
	logic            iRST;
	logic            iWrEn;
	dotPkg::regAddrT iWrAddr;
	dotPkg::regDataT iWrData;
	dotPkg::colorT   iBgColor;
	dotPkg::colorT   oPd;
	logic            oPv;
	dotPkg::hPosT    oHpos;
	dotPkg::vPosT    oVpos;
	logic            oFrameStart;

	// Model entry per rectangle
	// [38] half, [37:33] under, [32:28] top, [27:22] right, [21:16] left, [15:0] color
	logic [38:0] pen     [dotPkg::RectCount];
	logic [38:0] penHist [3][dotPkg::RectCount];
	logic [38:0] act     [dotPkg::RectCount];

	dotPkg::colorT bgQ;
	dotPkg::colorT expPd;
	dotPkg::hPosT  expH;
	dotPkg::vPosT  expV;
	logic          expPv;
	logic          expFs;
	int cnt = 0;
	int sinceRst = 0;
	int validCnt = 0;
	int lastLen = 0;
	int lastValid = 0;
	int framesSeen = 0;
	int pixChecked = 0;
	int colorErrors = 0;
	int timingErrors = 0;
	int timeoutErrors = 0;

	dotOverlayTop i_dut
	(
		.iCLK        (iCLK),
		.iRST        (iRST),
		.iWrEn       (iWrEn),
		.iWrAddr     (iWrAddr),
		.iWrData     (iWrData),
		.iBgColor    (iBgColor),
		.oPd         (oPd),
		.oPv         (oPv),
		.oHpos       (oHpos),
		.oVpos       (oVpos),
		.oFrameStart (oFrameStart)
	);

	initial
	begin
		iCLK = 1'b0;
		forever #5 iCLK = ~iCLK;
	end

	// ------------------------------------------------------------------------
	// Reference model
	// ------------------------------------------------------------------------
	task automatic storeWrite(input dotPkg::regAddrT addr, input dotPkg::regDataT data);
		int idx;
		idx = int'(addr[5:3]);
		case (addr[2:0])
			dotPkg::FieldColor: pen[idx][15:0]  = data;
			dotPkg::FieldLeft:  pen[idx][21:16] = data[5:0];
			dotPkg::FieldRight: pen[idx][27:22] = data[5:0];
			dotPkg::FieldTop:   pen[idx][32:28] = data[4:0];
			dotPkg::FieldUnder: pen[idx][37:33] = data[4:0];
			dotPkg::FieldHalf:  pen[idx][38]    = data[0];
			default: ;
		endcase
	endtask

	// Highest covering index wins and its half flag picks the blend
	function automatic dotPkg::colorT modelColor(input int h, input int v, input dotPkg::colorT bg);
		int sel;
		int r;
		int g;
		int b;
		logic [38:0] e;
		sel = -1;
		for (int i = 0; i < dotPkg::RectCount; i++)
		begin
			if (int'($signed(act[i][21:16])) <= h && h < int'($signed(act[i][27:22]))
				&& int'($signed(act[i][32:28])) <= v && v < int'($signed(act[i][37:33])))
				sel = i;
		end
		if (sel < 0)
			return bg;
		e = act[sel];
		if (!e[38])
			return e[15:0];
		r = (int'(e[15:11]) + int'(bg[15:11])) / 2;
		g = (int'(e[10:5]) + int'(bg[10:5])) / 2;
		b = (int'(e[4:0]) + int'(bg[4:0])) / 2;
		return dotPkg::colorT'((r << 11) | (g << 5) | b);
	endfunction

	// Pending bank after each edge with three edges of history
	always @(posedge iCLK)
	begin
		if (iRST)
		begin
			for (int i = 0; i < dotPkg::RectCount; i++)
			begin
				pen[i] = '0;
				for (int k = 0; k < 3; k++)
					penHist[k][i] = '0;
			end
		end
		else
		begin
			if (iWrEn)
				storeWrite(iWrAddr, iWrData);
			for (int i = 0; i < dotPkg::RectCount; i++)
			begin
				penHist[2][i] = penHist[1][i];
				penHist[1][i] = penHist[0][i];
				penHist[0][i] = pen[i];
			end
		end
		bgQ = iBgColor;
	end

	// Output frame start is two edges behind the commit
	always @(negedge iCLK)
	begin
		if (iRST)
		begin
			cnt = 0;
			sinceRst = 0;
			validCnt = 0;
			framesSeen = 0;
			for (int i = 0; i < dotPkg::RectCount; i++)
				act[i] = '0;
			expPv = 1'b0;
			expFs = 1'b0;
			expH  = '0;
			expV  = '0;
			expPd = '0;
		end
		else
		begin
			sinceRst++;
			expFs = (sinceRst >= FirstFs) && ((sinceRst - FirstFs) % FrameLen == 0);
			if (oFrameStart)
			begin
				lastLen   = cnt + 1;
				lastValid = validCnt;
				cnt       = 0;
				validCnt  = 0;
				framesSeen++;
				for (int i = 0; i < dotPkg::RectCount; i++)
					act[i] = penHist[2][i];
			end
			else
				cnt++;
			expH  = dotPkg::hPosT'(cnt % dotPkg::HTotal);
			expV  = dotPkg::vPosT'(cnt / dotPkg::HTotal);
			expPv = (framesSeen > 0) && (cnt % dotPkg::HTotal < dotPkg::HActive)
				&& (cnt / dotPkg::HTotal < dotPkg::VActive);
			expPd = modelColor(cnt % dotPkg::HTotal, cnt / dotPkg::HTotal, bgQ);
			if (oPv)
				validCnt++;
			if (oPv && framesSeen > 0)
				pixChecked++;
		end
	end

	// ------------------------------------------------------------------------
	// Checks
	// ------------------------------------------------------------------------
	colorCheck: assert property (@(posedge iCLK) disable iff (iRST)
		(oPv && framesSeen > 0) |-> (oPd == expPd))
		else
		begin
			colorErrors++;
			$display("mismatch oPd at (%0d,%0d): got %h expected %h",
				$sampled(oHpos), $sampled(oVpos), $sampled(oPd), expPd);
		end

	pvCheck: assert property (@(posedge iCLK) disable iff (iRST) oPv == expPv)
		else
		begin
			timingErrors++;
			$display("mismatch oPv: got %h expected %h", $sampled(oPv), expPv);
		end

	fsCheck: assert property (@(posedge iCLK) disable iff (iRST) oFrameStart == expFs)
		else
		begin
			timingErrors++;
			$display("mismatch oFrameStart: got %h expected %h", $sampled(oFrameStart), expFs);
		end

	posCheck: assert property (@(posedge iCLK) disable iff (iRST)
		(framesSeen > 0) |-> (oHpos == expH && oVpos == expV))
		else
		begin
			timingErrors++;
			$display("mismatch oHpos/oVpos: got %h/%h expected %h/%h",
				$sampled(oHpos), $sampled(oVpos), expH, expV);
		end

	frameLenCheck: assert property (@(posedge iCLK) disable iff (iRST)
		(oFrameStart && framesSeen >= 2) |-> (lastLen == FrameLen))
		else
		begin
			timingErrors++;
			$display("mismatch frame length: got %h expected %h", lastLen, FrameLen);
		end

	validCountCheck: assert property (@(posedge iCLK) disable iff (iRST)
		(oFrameStart && framesSeen >= 2) |-> (lastValid == PixPerFrm))
		else
		begin
			timingErrors++;
			$display("mismatch valid pixels per frame: got %h expected %h", lastValid, PixPerFrm);
		end

	// ------------------------------------------------------------------------
	// Stimulus
	// ------------------------------------------------------------------------
	task automatic finishRun();
		$display("checked %0d pixels, errors: color %0d, timing %0d, timeout %0d",
			pixChecked, colorErrors, timingErrors, timeoutErrors);
		if (colorErrors + timingErrors + timeoutErrors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	endtask

	task automatic waitFrameStart();
		int n;
		n = 0;
		do
		begin
			@(posedge iCLK);
			#1;
			n++;
		end
		while (oFrameStart !== 1'b1 && n < WaitLimit);
		if (oFrameStart !== 1'b1)
		begin
			timeoutErrors++;
			$display("timeout: no frame start within %0d cycles", WaitLimit);
			finishRun();
		end
	endtask

	// One-cycle write strobe
	task automatic writeReg(input int idx, input logic [2:0] field, input dotPkg::regDataT data);
		iWrEn   = 1'b1;
		iWrAddr = {3'(idx), field};
		iWrData = data;
		@(posedge iCLK);
		#1;
		iWrEn   = 1'b0;
	endtask

	task automatic loadRect(input int idx, input dotPkg::colorT color, input int left,
		input int right, input int top, input int under, input logic half);
		writeReg(idx, dotPkg::FieldColor, color);
		writeReg(idx, dotPkg::FieldLeft, dotPkg::regDataT'(left));
		writeReg(idx, dotPkg::FieldRight, dotPkg::regDataT'(right));
		writeReg(idx, dotPkg::FieldTop, dotPkg::regDataT'(top));
		writeReg(idx, dotPkg::FieldUnder, dotPkg::regDataT'(under));
		writeReg(idx, dotPkg::FieldHalf, {15'd0, half});
	endtask

	initial
	begin
		int l;
		int t;
		iRST    = 1'b1;
		iWrEn   = 1'b0;
		iWrAddr = '0;
		iWrData = '0;
		void'($urandom(32'ha4147d99));
		iBgColor = dotPkg::colorT'($urandom);
		repeat (2) @(posedge iCLK);
		#1;
		iRST = 1'b0;

		// Empty banks show only the background
		waitFrameStart();
		waitFrameStart();
		waitFrameStart();

		// Edges, overlap, off-screen parts and half strength
		loadRect(2, dotPkg::colorT'($urandom), 3, 9, 2, 7, 1'b0);
		loadRect(5, dotPkg::colorT'($urandom), 6, 12, 4, 10, 1'b0);
		loadRect(0, dotPkg::colorT'($urandom), -5, 4, -3, 3, 1'b0);
		loadRect(6, dotPkg::colorT'($urandom), 13, 25, 8, 15, 1'b1);
		loadRect(3, dotPkg::colorT'($urandom), 1, 15, 9, 11, 1'b1);
		waitFrameStart();
		waitFrameStart();

		// Change in mid frame is held back until the next frame start
		loadRect(5, dotPkg::colorT'($urandom), 0, 16, 0, 12, 1'b1);
		waitFrameStart();
		waitFrameStart();

		for (int s = 0; s < 4; s++)
		begin
			iBgColor = dotPkg::colorT'($urandom);
			for (int i = 0; i < dotPkg::RectCount; i++)
			begin
				l = int'($urandom_range(0, 20)) - 6;
				t = int'($urandom_range(0, 13)) - 4;
				loadRect(i, dotPkg::colorT'($urandom), l, l + int'($urandom_range(1, 12)),
					t, t + int'($urandom_range(1, 6)), ($urandom_range(0, 3) == 0));
			end
			waitFrameStart();
			waitFrameStart();
		end

		waitFrameStart();
		finishRun();
	end

endmodule

`default_nettype wire

/* flist.f */
logic/dotPkg.sv
logic/pixelIf.sv
logic/rectIf.sv
logic/scanControl.sv
logic/squareRegs.sv
logic/dotSquareGen.sv
logic/dotBlend.sv
logic/dotOverlayTop.sv
dv/dotOverlayTb.sv

/* run.sh */
#!/bin/sh
# Build and run the overlay testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module dotOverlayTb -f flist.f

./obj_dir/VdotOverlayTb | tee sim.log

if grep -q "TEST FAILED" sim.log; then
	echo "simulation reported failure"
	exit 1
fi
if ! grep -q "TEST PASSED" sim.log; then
	echo "simulation ended without a verdict"
	exit 1
fi
echo "simulation finished cleanly"
